//--- design/sprite_pkg.sv
package sprite_pkg;

	// Screen or line buffer coordinate
	typedef logic [8:0] position_t;
	// Sprite number in attribute RAM
	typedef logic [4:0] sprite_index_t;
	// Image number inside one size bank of sprite ROM
	typedef logic [6:0] image_index_t;
	// One of four palettes
	typedef logic [1:0] palette_sel_t;
	// Row inside a sprite image
	typedef logic [4:0] sprite_row_t;

	// Size code from attribute byte 0 bits 3:2
	typedef enum logic [1:0] {
		size_32 = 2'd0,
		size_16 = 2'd1,
		size_8 = 2'd2,
		// Old single pixel code, drawn as 8x8
		size_8_alt = 2'd3
	} sprite_size_e;

	// Attribute RAM walk
	typedef enum logic [3:0] {
		scan_idle,
		scan_addr,
		scan_wait,
		scan_attr,
		scan_y_low,
		scan_check_y,
		scan_x_high,
		scan_x_low,
		scan_job,
		scan_next
	} scan_state_e;

	// Offset table load and pixel loop
	typedef enum logic [3:0] {
		draw_init,
		draw_load_wait,
		draw_load,
		draw_idle,
		draw_rom_wait,
		draw_pixel,
		draw_pal_wait,
		draw_stage,
		draw_write
	} draw_state_e;

	// Left and top border in buffer coordinates
	localparam position_t border_width = 9'd32;
	// hcnt value where an unfinished line is dropped
	localparam position_t line_limit = 9'd329;
	// Attribute bytes per sprite
	localparam int ram_item_words = 4;

	// Width and height in pixels (sprites are square)
	function automatic position_t size_width(input sprite_size_e size);
		case (size)
			size_32: return 9'd32;
			size_16: return 9'd16;
			size_8, size_8_alt: return 9'd8;
			default: return 9'd8;
		endcase
	endfunction

endpackage

//--- design/video_pkg.sv
package video_pkg;

	// Palette colour
	// bit 15 alpha, 14:10 blue, 9:5 green, 4:0 red
	typedef logic [15:0] colour_t;

	// Expanded output channel
	typedef logic [7:0] channel_t;

	// Line buffer address
	// Top bit picks the slot, low 9 bits are the buffer position
	typedef logic [9:0] lb_addr_t;

	// Palette ROM address
	// {palette, colour index, 0}
	typedef logic [7:0] pal_addr_t;

	// Opaque flag inside colour_t
	localparam int alpha_bit = 15;

endpackage

//--- design/sprite_job_if.sv
interface sprite_job_if;

	// Handshake
	logic start;
	logic abort;
	logic ready;
	logic done;

	// Job fields, held by the scanner until done
	sprite_pkg::position_t x;
	sprite_pkg::sprite_size_e size;
	logic mirror;
	sprite_pkg::palette_sel_t palette;
	sprite_pkg::image_index_t image;
	sprite_pkg::sprite_row_t row;
	// Line buffer half being written
	logic slot;

	modport scanner (
		output start, abort, x, size, mirror, palette, image, row, slot,
		input ready, done
	);

	modport drawer (
		input start, abort, x, size, mirror, palette, image, row, slot,
		output ready, done
	);

endinterface

//--- design/sprite_line_scanner.sv
module sprite_line_scanner #(
	parameter int sprite_count = 32
)(
	input logic clk,
	input logic reset,
	input logic hsync,
	input sprite_pkg::position_t hcnt,
	input sprite_pkg::position_t vcnt,
	output logic [$clog2(sprite_count * sprite_pkg::ram_item_words)-1:0] spriteram_addr,
	input logic [7:0] spriteram_data,
	sprite_job_if.scanner job,
	output logic rd_slot
);

	typedef logic [$clog2(sprite_count * sprite_pkg::ram_item_words)-1:0] ram_addr_t;

	sprite_pkg::scan_state_e state;
	// State to enter after a RAM wait cycle
	sprite_pkg::scan_state_e ret_state;
	sprite_pkg::sprite_index_t index;
	// Line being built, in buffer coordinates
	sprite_pkg::position_t active_y;
	sprite_pkg::position_t y;
	logic hsync_last;
	logic hsync_rise;

	assign hsync_rise = hsync && !hsync_last;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sprite_pkg::scan_idle;
			hsync_last <= 1'b0;
			job.start <= 1'b0;
			job.abort <= 1'b0;
			// Read half 0, write half 1
			rd_slot <= 1'b0;
			job.slot <= 1'b1;
		end
		else
		begin
			hsync_last <= hsync;
			// Strobes are single cycle
			job.start <= 1'b0;
			job.abort <= 1'b0;

			case (state)
				sprite_pkg::scan_idle:
				begin
					// No lines until the offset table is in
					if (hsync_rise && job.ready)
					begin
						// Swap line buffer halves
						rd_slot <= ~rd_slot;
						job.slot <= ~job.slot;
						// vcnt 255 wraps to the first line
						if (vcnt == 9'd255)
							active_y <= sprite_pkg::border_width;
						else
							active_y <= vcnt + sprite_pkg::border_width + 9'd1;
						index <= '0;
						state <= sprite_pkg::scan_addr;
					end
				end

				sprite_pkg::scan_addr:
				begin
					// Byte 0 of this sprite
					spriteram_addr <= ram_addr_t'(index * sprite_pkg::ram_item_words);
					ret_state <= sprite_pkg::scan_attr;
					state <= sprite_pkg::scan_wait;
				end

				sprite_pkg::scan_wait:
				begin
					// RAM answers one cycle after the address
					state <= ret_state;
				end

				sprite_pkg::scan_attr:
				begin
					job.palette <= spriteram_data[5:4];
					job.size <= sprite_pkg::sprite_size_e'(spriteram_data[3:2]);
					job.mirror <= spriteram_data[1];
					y[8] <= spriteram_data[0];
					spriteram_addr <= spriteram_addr + 1'b1;
					// Disabled sprites stop here
					if (!spriteram_data[7])
					begin
						state <= sprite_pkg::scan_next;
					end
					else
					begin
						ret_state <= sprite_pkg::scan_y_low;
						state <= sprite_pkg::scan_wait;
					end
				end

				sprite_pkg::scan_y_low:
				begin
					y[7:0] <= spriteram_data;
					// Byte 2 is fetched while Y is tested
					spriteram_addr <= spriteram_addr + 1'b1;
					state <= sprite_pkg::scan_check_y;
				end

				sprite_pkg::scan_check_y:
				begin
					// Rows y to y + width - 1 must contain the active line
					if (active_y >= y && (active_y - y) < sprite_pkg::size_width(job.size))
					begin
						job.row <= sprite_pkg::sprite_row_t'(active_y - y);
						state <= sprite_pkg::scan_x_high;
					end
					else
					begin
						state <= sprite_pkg::scan_next;
					end
				end

				sprite_pkg::scan_x_high:
				begin
					job.image <= spriteram_data[7:1];
					job.x[8] <= spriteram_data[0];
					spriteram_addr <= spriteram_addr + 1'b1;
					ret_state <= sprite_pkg::scan_x_low;
					state <= sprite_pkg::scan_wait;
				end

				sprite_pkg::scan_x_low:
				begin
					job.x[7:0] <= spriteram_data;
					// Hand the row to the drawer
					job.start <= 1'b1;
					state <= sprite_pkg::scan_job;
				end

				sprite_pkg::scan_job:
				begin
					if (job.done)
						state <= sprite_pkg::scan_next;
				end

				sprite_pkg::scan_next:
				begin
					// Higher indices draw later and win on overlap
					if (index == sprite_pkg::sprite_index_t'(sprite_count - 1))
					begin
						state <= sprite_pkg::scan_idle;
					end
					else
					begin
						index <= index + 1'b1;
						state <= sprite_pkg::scan_addr;
					end
				end

				default:
				begin
					state <= sprite_pkg::scan_idle;
				end
			endcase

			// Failsafe so the next line is not lost
			if (state != sprite_pkg::scan_idle && hcnt == sprite_pkg::line_limit)
			begin
				job.abort <= 1'b1;
				job.start <= 1'b0;
				state <= sprite_pkg::scan_idle;
			end
		end
	end

endmodule

//--- design/sprite_pixel_drawer.sv
module sprite_pixel_drawer #(
	parameter int sprite_rom_width = 15
)(
	input logic clk,
	input logic reset,
	output logic [sprite_rom_width-1:0] sprom_addr,
	input logic [7:0] sprom_data,
	output video_pkg::pal_addr_t palrom_addr,
	input video_pkg::colour_t palrom_data,
	output video_pkg::lb_addr_t lb_wr_addr,
	output video_pkg::colour_t lb_wr_data,
	output logic lb_wr,
	sprite_job_if.drawer job
);

	typedef logic [sprite_rom_width-1:0] rom_addr_t;

	sprite_pkg::draw_state_e state;
	// Image bank bases for 32x32, 16x16 and 8x8
	rom_addr_t offsets [3];
	// ROM byte 0 to 5 of the offset table
	logic [2:0] load_count;
	// Pixels handled in the current row
	sprite_pkg::position_t pixel;
	sprite_pkg::position_t width;
	logic [1:0] size_sel;
	rom_addr_t image_base;
	rom_addr_t row_base;
	rom_addr_t first_addr;

	// First ROM byte of the job's row
	always_comb
	begin
		width = sprite_pkg::size_width(job.size);
		case (job.size)
			sprite_pkg::size_32:
			begin
				size_sel = 2'd0;
				// 1024 bytes per image, 32 per row
				image_base = rom_addr_t'({job.image, 10'b0});
				row_base = rom_addr_t'({job.row, 5'b0});
			end
			sprite_pkg::size_16:
			begin
				size_sel = 2'd1;
				image_base = rom_addr_t'({job.image, 8'b0});
				row_base = rom_addr_t'({job.row[3:0], 4'b0});
			end
			default:
			begin
				// 8x8 and the old single pixel code
				size_sel = 2'd2;
				image_base = rom_addr_t'({job.image, 6'b0});
				row_base = rom_addr_t'({job.row[2:0], 3'b0});
			end
		endcase
		first_addr = offsets[size_sel] + image_base + row_base;
		// Mirrored rows are read from the right end
		if (job.mirror)
			first_addr = first_addr + rom_addr_t'(width - 9'd1);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sprite_pkg::draw_init;
			job.ready <= 1'b0;
			job.done <= 1'b0;
			lb_wr <= 1'b0;
		end
		else
		begin
			job.done <= 1'b0;

			case (state)
				sprite_pkg::draw_init:
				begin
					sprom_addr <= '0;
					load_count <= 3'd0;
					state <= sprite_pkg::draw_load_wait;
				end

				sprite_pkg::draw_load_wait:
				begin
					// ROM data lags the address by a cycle
					state <= sprite_pkg::draw_load;
				end

				sprite_pkg::draw_load:
				begin
					// Even bytes are high halves
					if (!load_count[0])
						offsets[load_count[2:1]][sprite_rom_width-1:8] <=
							sprom_data[sprite_rom_width-9:0];
					else
						offsets[load_count[2:1]][7:0] <= sprom_data;
					sprom_addr <= sprom_addr + 1'b1;
					if (load_count == 3'd5)
					begin
						job.ready <= 1'b1;
						state <= sprite_pkg::draw_idle;
					end
					else
					begin
						load_count <= load_count + 3'd1;
						state <= sprite_pkg::draw_load_wait;
					end
				end

				sprite_pkg::draw_idle:
				begin
					if (job.start)
					begin
						sprom_addr <= first_addr;
						lb_wr_addr <= {job.slot, job.x};
						pixel <= '0;
						state <= sprite_pkg::draw_rom_wait;
					end
				end

				sprite_pkg::draw_rom_wait:
				begin
					state <= sprite_pkg::draw_pixel;
				end

				sprite_pkg::draw_pixel:
				begin
					if (pixel == width)
					begin
						job.done <= 1'b1;
						state <= sprite_pkg::draw_idle;
					end
					else
					begin
						// Low 5 bits pick the colour inside the palette
						palrom_addr <= {job.palette, sprom_data[4:0], 1'b0};
						// Step to the next image byte
						if (job.mirror)
							sprom_addr <= sprom_addr - 1'b1;
						else
							sprom_addr <= sprom_addr + 1'b1;
						state <= sprite_pkg::draw_pal_wait;
					end
				end

				sprite_pkg::draw_pal_wait:
				begin
					state <= sprite_pkg::draw_stage;
				end

				sprite_pkg::draw_stage:
				begin
					if (palrom_data[video_pkg::alpha_bit])
					begin
						lb_wr_data <= palrom_data;
						lb_wr <= 1'b1;
						state <= sprite_pkg::draw_write;
					end
					else
					begin
						// Transparent, leave the buffer alone
						lb_wr_addr <= {lb_wr_addr[9], lb_wr_addr[8:0] + 9'd1};
						pixel <= pixel + 9'd1;
						state <= sprite_pkg::draw_pixel;
					end
				end

				sprite_pkg::draw_write:
				begin
					lb_wr <= 1'b0;
					// Position wraps inside the slot
					lb_wr_addr <= {lb_wr_addr[9], lb_wr_addr[8:0] + 9'd1};
					pixel <= pixel + 9'd1;
					state <= sprite_pkg::draw_pixel;
				end

				default:
				begin
					state <= sprite_pkg::draw_idle;
				end
			endcase

			// Line dropped by the scanner
			if (job.ready && job.abort)
			begin
				lb_wr <= 1'b0;
				job.done <= 1'b0;
				state <= sprite_pkg::draw_idle;
			end
		end
	end

endmodule

//--- design/line_buffer_output.sv
module line_buffer_output (
	input logic clk,
	input logic reset,
	input sprite_pkg::position_t hcnt,
	input logic rd_slot,
	output video_pkg::lb_addr_t lb_rd_addr,
	input video_pkg::colour_t lb_rd_data,
	output logic lb_clear,
	output video_pkg::channel_t spr_r,
	output video_pkg::channel_t spr_g,
	output video_pkg::channel_t spr_b,
	output logic spr_a
);

	// Free running, one pixel every 4 cycles
	logic [1:0] phase;

	// 5-bit channel to 8 bits, top bits repeated below
	function automatic video_pkg::channel_t expand(input logic [4:0] level);
		return {level, level[4:2]};
	endfunction

	// Reader runs a border ahead of the screen
	assign lb_rd_addr = {rd_slot, sprite_pkg::position_t'(hcnt + sprite_pkg::border_width)};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= 2'd0;
			lb_clear <= 1'b0;
		end
		else
		begin
			phase <= phase + 2'd1;
			// Zero the location just read
			lb_clear <= (phase == 2'd0);
		end
	end

	always_ff @(posedge clk)
	begin
		if (phase == 2'd0)
		begin
			spr_r <= expand(lb_rd_data[4:0]);
			spr_g <= expand(lb_rd_data[9:5]);
			spr_b <= expand(lb_rd_data[14:10]);
			spr_a <= lb_rd_data[video_pkg::alpha_bit];
		end
	end

endmodule

//--- design/sprite_engine.sv
module sprite_engine #(
	parameter int sprite_rom_width = 15,
	parameter int sprite_count = 32
)(
	input logic clk,
	input logic reset,
	input logic hsync,
	input sprite_pkg::position_t hcnt,
	input sprite_pkg::position_t vcnt,
	output logic [$clog2(sprite_count * sprite_pkg::ram_item_words)-1:0] spriteram_addr,
	input logic [7:0] spriteram_data,
	output logic [sprite_rom_width-1:0] sprom_addr,
	input logic [7:0] sprom_data,
	output video_pkg::pal_addr_t palrom_addr,
	input video_pkg::colour_t palrom_data,
	output video_pkg::lb_addr_t lb_wr_addr,
	output video_pkg::colour_t lb_wr_data,
	output logic lb_wr,
	output video_pkg::lb_addr_t lb_rd_addr,
	input video_pkg::colour_t lb_rd_data,
	output logic lb_clear,
	output video_pkg::channel_t spr_r,
	output video_pkg::channel_t spr_g,
	output video_pkg::channel_t spr_b,
	output logic spr_a
);

	// Line buffer half being read out
	logic rd_slot;

	// Scanner to drawer job channel
	sprite_job_if job ();

	// Attribute walk and Y test
	sprite_line_scanner #(
		.sprite_count(sprite_count)
	) scanner0 (
		.clk(clk),
		.reset(reset),
		.hsync(hsync),
		.hcnt(hcnt),
		.vcnt(vcnt),
		.spriteram_addr(spriteram_addr),
		.spriteram_data(spriteram_data),
		.job(job.scanner),
		.rd_slot(rd_slot)
	);

	// Image fetch and line buffer writes
	sprite_pixel_drawer #(
		.sprite_rom_width(sprite_rom_width)
	) drawer0 (
		.clk(clk),
		.reset(reset),
		.sprom_addr(sprom_addr),
		.sprom_data(sprom_data),
		.palrom_addr(palrom_addr),
		.palrom_data(palrom_data),
		.lb_wr_addr(lb_wr_addr),
		.lb_wr_data(lb_wr_data),
		.lb_wr(lb_wr),
		.job(job.drawer)
	);

	// Readout of the other half
	line_buffer_output output0 (
		.clk(clk),
		.reset(reset),
		.hcnt(hcnt),
		.rd_slot(rd_slot),
		.lb_rd_addr(lb_rd_addr),
		.lb_rd_data(lb_rd_data),
		.lb_clear(lb_clear),
		.spr_r(spr_r),
		.spr_g(spr_g),
		.spr_b(spr_b),
		.spr_a(spr_a)
	);

endmodule

//--- tests/video_mem_model.sv
module video_mem_model #(
	parameter int rom_width = 15,
	parameter int ram_addr_width = 7
)(
	input logic clk,
	input logic [ram_addr_width-1:0] spriteram_addr,
	output logic [7:0] spriteram_data,
	input logic [rom_width-1:0] sprom_addr,
	output logic [7:0] sprom_data,
	input video_pkg::pal_addr_t palrom_addr,
	output video_pkg::colour_t palrom_data,
	input video_pkg::lb_addr_t lb_wr_addr,
	input video_pkg::colour_t lb_wr_data,
	input logic lb_wr,
	input video_pkg::lb_addr_t lb_rd_addr,
	output video_pkg::colour_t lb_rd_data,
	input logic lb_clear
);

	// Sprite attributes, 4 bytes per sprite
	logic [7:0] spriteram [1 << ram_addr_width];
	// Offset table and image bytes
	logic [7:0] sprom [1 << rom_width];
	// One colour per address
	video_pkg::colour_t palrom [256];
	// Both halves of the line buffer
	video_pkg::colour_t lb [1024];

	initial
	begin
		for (int i = 0; i < 1024; i++)
			lb[i] = '0;
	end

	// All reads answer one cycle after the address
	always @(posedge clk)
	begin
		spriteram_data <= spriteram[spriteram_addr];
		sprom_data <= sprom[sprom_addr];
		palrom_data <= palrom[palrom_addr];
		lb_rd_data <= lb[lb_rd_addr];
		// Clear behind the reader
		if (lb_clear)
			lb[lb_rd_addr] <= '0;
		// Write port, never in the half being read
		if (lb_wr)
			lb[lb_wr_addr] <= lb_wr_data;
	end

endmodule

//--- tests/sprite_engine_tb.sv
module sprite_engine_tb;

	localparam int rom_width = 15;
	localparam int sprite_count = 32;
	localparam int line_timeout = 20000;
	// Image bank bases placed in ROM bytes 0 to 5
	localparam logic [14:0] offset_32 = 15'h0400;
	localparam logic [14:0] offset_16 = 15'h2000;
	localparam logic [14:0] offset_8 = 15'h3000;
	// hcnt while lines are built, far from the swept range and the limit
	localparam sprite_pkg::position_t idle_hcnt = 9'd400;

	logic clk;
	logic reset;
	logic hsync;
	sprite_pkg::position_t hcnt;
	sprite_pkg::position_t vcnt;
	logic [6:0] spriteram_addr;
	logic [7:0] spriteram_data;
	logic [rom_width-1:0] sprom_addr;
	logic [7:0] sprom_data;
	video_pkg::pal_addr_t palrom_addr;
	video_pkg::colour_t palrom_data;
	video_pkg::lb_addr_t lb_wr_addr;
	video_pkg::colour_t lb_wr_data;
	logic lb_wr;
	video_pkg::lb_addr_t lb_rd_addr;
	video_pkg::colour_t lb_rd_data;
	logic lb_clear;
	video_pkg::channel_t spr_r;
	video_pkg::channel_t spr_g;
	video_pkg::channel_t spr_b;
	logic spr_a;

	int errors;
	int checks;
	// lb_wr cycles in the current line
	int write_count;
	// Opaque pixels the reference drew
	int ref_writes;
	// Half the next line writes, and the half of the last line
	logic draw_slot;
	logic line_slot;
	video_pkg::colour_t expected_lb [512];

	sprite_engine #(
		.sprite_rom_width(rom_width),
		.sprite_count(sprite_count)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.hsync(hsync),
		.hcnt(hcnt),
		.vcnt(vcnt),
		.spriteram_addr(spriteram_addr),
		.spriteram_data(spriteram_data),
		.sprom_addr(sprom_addr),
		.sprom_data(sprom_data),
		.palrom_addr(palrom_addr),
		.palrom_data(palrom_data),
		.lb_wr_addr(lb_wr_addr),
		.lb_wr_data(lb_wr_data),
		.lb_wr(lb_wr),
		.lb_rd_addr(lb_rd_addr),
		.lb_rd_data(lb_rd_data),
		.lb_clear(lb_clear),
		.spr_r(spr_r),
		.spr_g(spr_g),
		.spr_b(spr_b),
		.spr_a(spr_a)
	);

	video_mem_model #(
		.rom_width(rom_width),
		.ram_addr_width(7)
	) mem0 (
		.clk(clk),
		.spriteram_addr(spriteram_addr),
		.spriteram_data(spriteram_data),
		.sprom_addr(sprom_addr),
		.sprom_data(sprom_data),
		.palrom_addr(palrom_addr),
		.palrom_data(palrom_data),
		.lb_wr_addr(lb_wr_addr),
		.lb_wr_data(lb_wr_data),
		.lb_wr(lb_wr),
		.lb_rd_addr(lb_rd_addr),
		.lb_rd_data(lb_rd_data),
		.lb_clear(lb_clear)
	);

	always #4 clk = ~clk;

	// Counts pixel writes of the running line
	always @(posedge clk)
	begin
		if (lb_wr)
			write_count = write_count + 1;
	end

	task automatic compare_value(input string test_name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		assert (expected === actual)
		else
		begin
			errors++;
			$display("[FAIL] %s %s expected %0h actual %0h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_condition(input string test_name, input logic cond,
			input string message);
		checks++;
		assert (cond === 1'b1)
		else
		begin
			errors++;
			$display("%s: %s", test_name, message);
		end
	endtask

	// Ends a run that stopped making progress
	task automatic give_up(input string message);
		$display("timeout: %s", message);
		$display("checks %0d errors %0d", checks, errors + 1);
		$display("tests failed");
		$finish;
	endtask

	function automatic logic scanner_busy();
		return dut0.scanner0.state != sprite_pkg::scan_idle;
	endfunction

	// Line in buffer coordinates for a vcnt value
	function automatic sprite_pkg::position_t active_line(input sprite_pkg::position_t v);
		if (v == 9'd255)
			return 9'd32;
		return 9'(v + 9'd33);
	endfunction

	// 5-bit level scaled by 8, plus its top 3 bits as the low fill
	function automatic video_pkg::channel_t expand_level(input logic [4:0] level);
		return 8'(level * 8 + level / 4);
	endfunction

	// All sprites disabled, bytes still tied to the address
	task automatic clear_sprites();
		int a;
		for (a = 0; a < 128; a++)
			mem0.spriteram[a] = 8'(a) & 8'h7f;
	endtask

	task automatic set_sprite(input int index, input logic enable, input logic [1:0] palette,
			input logic [1:0] size, input logic mirror, input logic [8:0] x,
			input logic [8:0] y, input logic [6:0] image);
		mem0.spriteram[index * 4] = {enable, 1'b0, palette, size, mirror, y[8]};
		mem0.spriteram[index * 4 + 1] = y[7:0];
		mem0.spriteram[index * 4 + 2] = {image, x[8]};
		mem0.spriteram[index * 4 + 3] = x[7:0];
	endtask

	task automatic fill_palette_opaque();
		int a;
		for (a = 0; a < 256; a++)
			mem0.palrom[a] = {1'b1, 15'(a * 97 + 3)};
	endtask

	// About half the entries transparent
	task automatic fill_palette_random();
		int a;
		for (a = 0; a < 256; a++)
			mem0.palrom[a] = 16'($urandom);
	endtask

	task automatic fill_rom_random(input logic [14:0] start, input int count);
		int i;
		for (i = 0; i < count; i++)
			mem0.sprom[15'(start + i)] = 8'($urandom);
	endtask

	// Expected write half after one line, from the memory contents
	task automatic draw_reference(input sprite_pkg::position_t v);
		sprite_pkg::position_t line;
		logic [7:0] b0;
		logic [7:0] b2;
		logic [8:0] x;
		logic [8:0] y;
		logic [14:0] base;
		logic [14:0] addr;
		logic [7:0] pixel_byte;
		video_pkg::colour_t colour;
		int i;
		int p;
		int width;
		int row;
		line = active_line(v);
		ref_writes = 0;
		for (p = 0; p < 512; p++)
			expected_lb[p] = '0;
		// Index order, so later sprites overwrite earlier ones
		for (i = 0; i < sprite_count; i++)
		begin
			b0 = mem0.spriteram[i * 4];
			b2 = mem0.spriteram[i * 4 + 2];
			y = {b0[0], mem0.spriteram[i * 4 + 1]};
			x = {b2[0], mem0.spriteram[i * 4 + 3]};
			case (b0[3:2])
				2'd0:
				begin
					width = 32;
					base = offset_32;
				end
				2'd1:
				begin
					width = 16;
					base = offset_16;
				end
				default:
				begin
					width = 8;
					base = offset_8;
				end
			endcase
			if (b0[7] && line >= y && int'(line - y) < width)
			begin
				row = int'(line - y);
				base = base + 15'(b2[7:1] * width * width) + 15'(row * width);
				for (p = 0; p < width; p++)
				begin
					addr = b0[1] ? base + 15'(width - 1 - p) : base + 15'(p);
					pixel_byte = mem0.sprom[addr];
					colour = mem0.palrom[{b0[5:4], pixel_byte[4:0], 1'b0}];
					if (colour[15])
					begin
						expected_lb[(x + p) % 512] = colour;
						ref_writes++;
					end
				end
			end
		end
	endtask

	// Pulses hsync and waits until the scanner has taken the line
	task automatic start_line(input sprite_pkg::position_t v);
		int i;
		int count;
		@(negedge clk);
		// Fresh half for the coming line
		for (i = 0; i < 512; i++)
			mem0.lb[{draw_slot, 9'(i)}] = '0;
		write_count = 0;
		line_slot = draw_slot;
		draw_slot = ~draw_slot;
		@(posedge clk);
		hsync <= 1'b1;
		vcnt <= v;
		count = 0;
		@(negedge clk);
		while (!scanner_busy())
		begin
			@(negedge clk);
			count++;
			if (count > 16)
				give_up("scanner did not start a line after hsync");
		end
		@(posedge clk);
		hsync <= 1'b0;
	endtask

	task automatic finish_line();
		int count;
		count = 0;
		while (scanner_busy())
		begin
			@(negedge clk);
			count++;
			if (count > line_timeout)
				give_up("scanner did not finish the line");
		end
	endtask

	task automatic compare_line(input string test_name);
		int p;
		for (p = 0; p < 512; p++)
			compare_value(test_name, $sformatf("slot %0d pos %0d", line_slot, p),
				expected_lb[p], mem0.lb[{line_slot, 9'(p)}]);
		compare_value(test_name, "write count", ref_writes, write_count);
	endtask

	task automatic run_line(input sprite_pkg::position_t v, input string test_name);
		start_line(v);
		finish_line();
		draw_reference(v);
		compare_line(test_name);
	endtask

	task automatic wait_clear_pulse();
		int count;
		count = 0;
		@(negedge clk);
		while (!lb_clear)
		begin
			@(negedge clk);
			count++;
			if (count > 8)
				give_up("no clear pulse from the output block");
		end
	endtask

	// One readout step, aligned so the clear hits the same address
	task automatic read_position(input int h, input logic slot);
		video_pkg::lb_addr_t addr;
		video_pkg::colour_t colour;
		addr = {slot, 9'(h + 32)};
		colour = expected_lb[h + 32];
		wait_clear_pulse();
		@(posedge clk);
		hcnt <= 9'(h);
		// Next pulse follows a sample of the new address
		wait_clear_pulse();
		compare_value("readout", $sformatf("rd addr h %0d", h), addr, lb_rd_addr);
		compare_value("readout", $sformatf("red h %0d", h), expand_level(colour[4:0]), spr_r);
		compare_value("readout", $sformatf("green h %0d", h), expand_level(colour[9:5]), spr_g);
		compare_value("readout", $sformatf("blue h %0d", h), expand_level(colour[14:10]), spr_b);
		compare_value("readout", $sformatf("alpha h %0d", h), colour[15], spr_a);
		@(negedge clk);
		compare_value("readout", $sformatf("cleared h %0d", h), 0, mem0.lb[addr]);
	endtask

	task automatic test_sizes();
		clear_sprites();
		fill_palette_opaque();
		// vcnt 40 gives line 73
		set_sprite(0, 1'b1, 2'd0, 2'd0, 1'b0, 9'd40, 9'd60, 7'd2);
		set_sprite(1, 1'b1, 2'd1, 2'd1, 1'b0, 9'd120, 9'd70, 7'd5);
		set_sprite(2, 1'b1, 2'd2, 2'd2, 1'b0, 9'd200, 9'd73, 7'd9);
		// Code 3 drawn as 8x8
		set_sprite(3, 1'b1, 2'd3, 2'd3, 1'b0, 9'd260, 9'd66, 7'd1);
		run_line(9'd40, "sizes");
		compare_value("sizes", "opaque pixels", 32 + 16 + 8 + 8, write_count);
	endtask

	task automatic test_transparency();
		clear_sprites();
		fill_palette_random();
		fill_rom_random(offset_16 + 15'd768, 256);
		fill_rom_random(offset_32 + 15'd1024, 1024);
		// vcnt 100 gives line 133
		set_sprite(0, 1'b1, 2'd2, 2'd1, 1'b0, 9'd60, 9'd128, 7'd3);
		set_sprite(1, 1'b1, 2'd1, 2'd0, 1'b0, 9'd90, 9'd110, 7'd1);
		run_line(9'd100, "transparency");
		check_condition("transparency", write_count > 0 && write_count < 48,
			"transparent pixels were written or no pixel was written");
	endtask

	task automatic test_mirror();
		int p;
		clear_sprites();
		fill_palette_opaque();
		// Same image and row, one mirrored
		set_sprite(0, 1'b1, 2'd1, 2'd1, 1'b1, 9'd50, 9'd40, 7'd3);
		set_sprite(1, 1'b1, 2'd1, 2'd1, 1'b0, 9'd150, 9'd40, 7'd3);
		run_line(9'd10, "mirror");
		for (p = 0; p < 16; p++)
			compare_value("mirror", $sformatf("reversed pixel %0d", p),
				mem0.lb[{line_slot, 9'(150 + p)}], mem0.lb[{line_slot, 9'(65 - p)}]);
	endtask

	task automatic test_rejection();
		int p;
		logic empty;
		clear_sprites();
		fill_palette_opaque();
		// vcnt 255 gives line 32
		set_sprite(0, 1'b0, 2'd0, 2'd2, 1'b0, 9'd20, 9'd30, 7'd1);
		set_sprite(1, 1'b1, 2'd0, 2'd2, 1'b0, 9'd40, 9'd33, 7'd1);
		set_sprite(2, 1'b1, 2'd0, 2'd1, 1'b0, 9'd60, 9'd10, 7'd1);
		set_sprite(3, 1'b1, 2'd1, 2'd2, 1'b0, 9'd100, 9'd28, 7'd4);
		// Overlaps sprite 3 from 104 on and must win there
		set_sprite(4, 1'b1, 2'd2, 2'd1, 1'b0, 9'd104, 9'd20, 7'd6);
		run_line(9'd255, "rejection");
		empty = 1'b1;
		for (p = 20; p < 76; p++)
			if (mem0.lb[{line_slot, 9'(p)}] != '0)
				empty = 1'b0;
		check_condition("rejection", empty, "a rejected sprite wrote into the line buffer");
		compare_value("rejection", "opaque pixels", 8 + 16, write_count);
	endtask

	task automatic test_readout();
		int h;
		logic read_slot;
		clear_sprites();
		fill_palette_random();
		fill_rom_random(offset_32 + 15'd1024, 1024);
		fill_rom_random(offset_8 + 15'd128, 64);
		// vcnt 50 gives line 83
		set_sprite(0, 1'b1, 2'd0, 2'd0, 1'b0, 9'd40, 9'd70, 7'd1);
		set_sprite(1, 1'b1, 2'd3, 2'd2, 1'b1, 9'd70, 9'd80, 7'd2);
		run_line(9'd50, "readout");
		read_slot = line_slot;
		// Empty line only to swap the halves
		clear_sprites();
		start_line(9'd51);
		finish_line();
		for (h = 0; h < 80; h++)
			read_position(h, read_slot);
		@(posedge clk);
		hcnt <= idle_hcnt;
	endtask

	task automatic test_failsafe();
		int i;
		int h;
		logic quiet;
		clear_sprites();
		fill_palette_opaque();
		// vcnt 60 gives line 93, every sprite covers it
		for (i = 0; i < sprite_count; i++)
			set_sprite(i, 1'b1, 2'(i), 2'd0, 1'b0, 9'(i * 8), 9'd90, 7'(i % 4));
		start_line(9'd60);
		for (h = 0; h < 330; h++)
		begin
			@(posedge clk);
			hcnt <= 9'(h);
		end
		@(negedge clk);
		check_condition("failsafe", scanner_busy(), "line ended before the line limit");
		check_condition("failsafe", write_count > 0, "no pixels written before the limit");
		// One cycle for the limit, one for the abort
		@(posedge clk);
		@(posedge clk);
		quiet = 1'b1;
		for (i = 0; i < 64; i++)
		begin
			@(negedge clk);
			if (lb_wr || scanner_busy())
				quiet = 1'b0;
		end
		check_condition("failsafe", quiet, "writes or scanning went on after the line limit");
		@(posedge clk);
		hcnt <= idle_hcnt;
		// The next line must run normally
		clear_sprites();
		run_line(9'd61, "failsafe next line");
	endtask

	initial
	begin
		int a;
		void'($urandom(40920));
		errors = 0;
		checks = 0;
		write_count = 0;
		ref_writes = 0;
		draw_slot = 1'b0;
		line_slot = 1'b0;
		clk = 1'b0;
		reset = 1'b1;
		hsync = 1'b0;
		hcnt = idle_hcnt;
		vcnt = '0;
		// Memory contents before the offset load
		for (a = 0; a < (1 << rom_width); a++)
			mem0.sprom[a] = 8'(a ^ (a >> 7));
		mem0.sprom[0] = {1'b0, offset_32[14:8]};
		mem0.sprom[1] = offset_32[7:0];
		mem0.sprom[2] = {1'b0, offset_16[14:8]};
		mem0.sprom[3] = offset_16[7:0];
		mem0.sprom[4] = {1'b0, offset_8[14:8]};
		mem0.sprom[5] = offset_8[7:0];
		fill_palette_opaque();
		clear_sprites();
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		// Offset table load
		a = 0;
		@(negedge clk);
		while (dut0.job.ready !== 1'b1)
		begin
			@(negedge clk);
			a++;
			if (a > 100)
				give_up("offset table never loaded");
		end
		test_sizes();
		test_transparency();
		test_mirror();
		test_rejection();
		test_readout();
		test_failsafe();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- flist.f
design/sprite_pkg.sv
design/video_pkg.sv
design/sprite_job_if.sv
design/sprite_line_scanner.sv
design/sprite_pixel_drawer.sv
design/line_buffer_output.sv
design/sprite_engine.sv
tests/video_mem_model.sv
tests/sprite_engine_tb.sv
